// ==== rtl/tpu_types_pkg.sv ====
package tpu_types_pkg;

    // array geometry
    localparam int ARRAY_DIM = 4;

    // element and accumulator widths
    localparam int ELEM_W = 8;
    localparam int ACC_W  = 32;

    // memory index and job dimension widths
    localparam int IDX_W = 16;
    localparam int DIM_W = 8;

    // last skewed element needs 2*dim-1 hops plus one skew stage and one pe stage
    localparam int DRAIN_CYCLES = 2 * ARRAY_DIM + 1;

    // single int8 operand
    typedef logic signed [ELEM_W-1:0] elem_t;

    // accumulator, result element and input offset
    typedef logic signed [ACC_W-1:0] acc_t;

    // four packed operands, byte 3 is lane 0
    typedef logic [ARRAY_DIM*ELEM_W-1:0] op_word_t;

    // one result row for C, column 0 in the top 32 bits
    typedef logic [ARRAY_DIM*ACC_W-1:0] res_row_t;

    typedef logic [IDX_W-1:0] mem_idx_t;
    typedef logic [DIM_W-1:0] dim_t;

endpackage

// ==== rtl/tpu_ctrl_pkg.sv ====
package tpu_ctrl_pkg;

    import tpu_types_pkg::*;

    // job sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_calc,
        st_drain,
        st_write
    } tpu_state_e;

    // job parameters, sampled on in_valid
    typedef struct packed {
        dim_t k;
        dim_t m;
        dim_t n;
        acc_t input_offset;
    } job_t;

    // operand memory read port, data returns one cycle after index
    typedef struct packed {
        mem_idx_t index;
        op_word_t data;
    } op_rd_t;

    // result memory write port
    typedef struct packed {
        logic     wr_en;
        mem_idx_t index;
        res_row_t data;
    } res_wr_t;

endpackage

// ==== rtl/pe.sv ====
`timescale 1ns/1ps

module pe
    import tpu_types_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic acc_clear,
    input  acc_t top,
    input  acc_t left,
    output acc_t bot,
    output acc_t right,
    output acc_t acc
);

    // operands hop one cell per cycle, product added every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bot   <= '0;
            right <= '0;
            acc   <= '0;
        end else if (acc_clear) begin
            bot   <= '0;
            right <= '0;
            acc   <= '0;
        end else begin
            bot   <= top;
            right <= left;
            // 32-bit wraparound
            acc   <= acc + top * left;
        end
    end

endmodule

// ==== rtl/systolic_array.sv ====
`timescale 1ns/1ps

module systolic_array
    import tpu_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 acc_clear,
    input  acc_t [ARRAY_DIM-1:0] a_col,
    input  acc_t [ARRAY_DIM-1:0] b_row,
    input  logic [1:0]           wr_row,
    output res_row_t             row_out
);

    // a travels right along each row, b travels down each column
    acc_t a_link   [ARRAY_DIM][ARRAY_DIM+1];
    acc_t b_link   [ARRAY_DIM+1][ARRAY_DIM];
    acc_t acc_grid [ARRAY_DIM][ARRAY_DIM];

    for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_feed_b
        assign b_link[0][c] = b_row[c];
    end

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        assign a_link[r][0] = a_col[r];

        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
            pe pe_inst (
                .clk       (clk),
                .rst_n     (rst_n),
                .acc_clear (acc_clear),
                .top       (b_link[r][c]),
                .left      (a_link[r][c]),
                .bot       (b_link[r+1][c]),
                .right     (a_link[r][c+1]),
                .acc       (acc_grid[r][c])
            );
        end
    end

    // selected row, column 0 goes to the top word
    always_comb begin
        row_out = '0;
        for (int c = 0; c < ARRAY_DIM; c++) begin
            row_out[(ARRAY_DIM-1-c)*ACC_W +: ACC_W] = acc_grid[wr_row][c];
        end
    end

endmodule

// ==== rtl/operand_skew.sv ====
`timescale 1ns/1ps

module operand_skew
    import tpu_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 feed,
    input  acc_t                 input_offset,
    input  op_word_t             a_data,
    input  op_word_t             b_data,
    output acc_t [ARRAY_DIM-1:0] a_col,
    output acc_t [ARRAY_DIM-1:0] b_row
);

    acc_t [ARRAY_DIM-1:0] a_elem;
    acc_t [ARRAY_DIM-1:0] b_elem;

    // sign-extended lane of a word, byte 3 is lane 0
    function automatic acc_t lane_of(op_word_t word, int lane);
        elem_t e;
        e = word[(ARRAY_DIM-1-lane)*ELEM_W +: ELEM_W];
        return acc_t'(e);
    endfunction

    // offset goes on A only, zeros between bursts
    always_comb begin
        for (int i = 0; i < ARRAY_DIM; i++) begin
            if (feed) begin
                a_elem[i] = lane_of(a_data, i) + input_offset;
                b_elem[i] = lane_of(b_data, i);
            end else begin
                a_elem[i] = '0;
                b_elem[i] = '0;
            end
        end
    end

    // staircase, lane i is i+1 registers deep
    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_lane
        acc_t a_pipe [i+1];
        acc_t b_pipe [i+1];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                for (int s = 0; s <= i; s++) begin
                    a_pipe[s] <= '0;
                    b_pipe[s] <= '0;
                end
            end else begin
                a_pipe[0] <= a_elem[i];
                b_pipe[0] <= b_elem[i];
                for (int s = 1; s <= i; s++) begin
                    a_pipe[s] <= a_pipe[s-1];
                    b_pipe[s] <= b_pipe[s-1];
                end
            end
        end

        assign a_col[i] = a_pipe[i];
        assign b_row[i] = b_pipe[i];
    end

endmodule

// ==== rtl/tpu_ctrl.sv ====
`timescale 1ns/1ps

module tpu_ctrl
    import tpu_types_pkg::*;
    import tpu_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  job_t       job,
    output logic       busy,
    output mem_idx_t   a_idx,
    output mem_idx_t   b_idx,
    output logic       feed,
    output logic       acc_clear,
    output logic [1:0] wr_row,
    output logic       c_wr_en,
    output mem_idx_t   c_idx,
    output acc_t       input_offset
);

    tpu_state_e state;
    tpu_state_e state_nx;
    job_t       job_q;

    dim_t k_cnt;
    dim_t row_tile;
    dim_t col_tile;
    dim_t row_tiles;
    dim_t col_tiles;

    logic [$clog2(DRAIN_CYCLES)-1:0] drain_cnt;

    // tile bases, A restarts per column tile, B grows by K per column tile
    mem_idx_t a_base;
    mem_idx_t b_base;

    logic calc_last;
    logic drain_last;
    logic write_last;
    logic last_row_tile;
    logic last_col_tile;

    // dimensions rounded up to whole tiles
    assign row_tiles = dim_t'(({1'b0, job_q.m} + ARRAY_DIM - 1) / ARRAY_DIM);
    assign col_tiles = dim_t'(({1'b0, job_q.n} + ARRAY_DIM - 1) / ARRAY_DIM);

    assign calc_last     = ({1'b0, k_cnt} + 9'd1) >= {1'b0, job_q.k};
    assign drain_last    = drain_cnt == ($bits(drain_cnt))'(DRAIN_CYCLES - 1);
    assign write_last    = (state == st_write) && (wr_row == 2'(ARRAY_DIM - 1));
    assign last_row_tile = ({1'b0, row_tile} + 9'd1) >= {1'b0, row_tiles};
    assign last_col_tile = ({1'b0, col_tile} + 9'd1) >= {1'b0, col_tiles};

    always_comb begin
        state_nx = state;
        unique case (state)
            st_idle: begin
                if (in_valid) state_nx = st_calc;
            end
            st_calc: begin
                if (calc_last) state_nx = st_drain;
            end
            st_drain: begin
                if (drain_last) state_nx = st_write;
            end
            st_write: begin
                if (write_last) begin
                    state_nx = (last_row_tile && last_col_tile) ? st_idle : st_calc;
                end
            end
            default: state_nx = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            feed  <= 1'b0;
        end else begin
            state <= state_nx;
            // memory answers one cycle after the index
            feed  <= (state == st_calc);
        end
    end

    // job fields only move while idle
    always_ff @(posedge clk) begin
        if (state == st_idle && in_valid) begin
            job_q <= job;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k_cnt     <= '0;
            drain_cnt <= '0;
            wr_row    <= '0;
            row_tile  <= '0;
            col_tile  <= '0;
            a_base    <= '0;
            b_base    <= '0;
            c_idx     <= '0;
        end else if (state == st_idle) begin
            k_cnt     <= '0;
            drain_cnt <= '0;
            wr_row    <= '0;
            row_tile  <= '0;
            col_tile  <= '0;
            a_base    <= '0;
            b_base    <= '0;
            c_idx     <= '0;
        end else begin
            unique case (state)
                st_calc: begin
                    k_cnt <= calc_last ? '0 : k_cnt + 8'd1;
                end
                st_drain: begin
                    drain_cnt <= drain_last ? '0 : drain_cnt + 1'b1;
                end
                st_write: begin
                    wr_row <= wr_row + 2'd1;
                    // tiles are written in order, so C index just counts
                    c_idx  <= c_idx + 16'd1;
                    if (write_last) begin
                        if (last_row_tile) begin
                            row_tile <= '0;
                            a_base   <= '0;
                            col_tile <= col_tile + 8'd1;
                            b_base   <= b_base + mem_idx_t'(job_q.k);
                        end else begin
                            row_tile <= row_tile + 8'd1;
                            a_base   <= a_base + mem_idx_t'(job_q.k);
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    assign a_idx        = a_base + mem_idx_t'(k_cnt);
    assign b_idx        = b_base + mem_idx_t'(k_cnt);
    assign busy         = (state != st_idle);
    assign c_wr_en      = (state == st_write);
    // accumulators empty once the last row is out
    assign acc_clear    = write_last;
    assign input_offset = job_q.input_offset;

endmodule

// ==== rtl/tpu_top.sv ====
`timescale 1ns/1ps

module tpu_top
    import tpu_types_pkg::*;
    import tpu_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  job_t     job,
    output logic     busy,
    output mem_idx_t a_idx,
    output mem_idx_t b_idx,
    input  op_word_t a_data,
    input  op_word_t b_data,
    output res_wr_t  c_wr
);

    logic                 feed;
    logic                 acc_clear;
    logic [1:0]           wr_row;
    logic                 c_wr_en;
    mem_idx_t             c_idx;
    acc_t                 input_offset;
    acc_t [ARRAY_DIM-1:0] a_col;
    acc_t [ARRAY_DIM-1:0] b_row;
    res_row_t             row_out;

    tpu_ctrl tpu_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .job          (job),
        .busy         (busy),
        .a_idx        (a_idx),
        .b_idx        (b_idx),
        .feed         (feed),
        .acc_clear    (acc_clear),
        .wr_row       (wr_row),
        .c_wr_en      (c_wr_en),
        .c_idx        (c_idx),
        .input_offset (input_offset)
    );

    operand_skew operand_skew_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .feed         (feed),
        .input_offset (input_offset),
        .a_data       (a_data),
        .b_data       (b_data),
        .a_col        (a_col),
        .b_row        (b_row)
    );

    systolic_array systolic_array_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_clear (acc_clear),
        .a_col     (a_col),
        .b_row     (b_row),
        .wr_row    (wr_row),
        .row_out   (row_out)
    );

    assign c_wr = '{wr_en: c_wr_en, index: c_idx, data: row_out};

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== dv/tpu_assert.sv ====
`timescale 1ns/1ps

module tpu_assert
    import tpu_types_pkg::*;
    import tpu_ctrl_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    busy,
    input res_wr_t c_wr
);

    mem_idx_t last_idx;
    logic     seen_write;

    // index of the previous write in the current job
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_idx   <= '0;
            seen_write <= 1'b0;
        end else if (!busy) begin
            seen_write <= 1'b0;
        end else if (c_wr.wr_en) begin
            last_idx   <= c_wr.index;
            seen_write <= 1'b1;
        end
    end

    write_in_job: assert property (
        @(posedge clk) disable iff (!rst_n) c_wr.wr_en |-> busy
    ) else $error("C write strobe while busy is low");

    index_steps_by_one: assert property (
        @(posedge clk) disable iff (!rst_n)
        (c_wr.wr_en && seen_write) |-> (c_wr.index == last_idx + 16'd1)
    ) else $error("C write index did not follow the previous one");

    index_known: assert property (
        @(posedge clk) disable iff (!rst_n) c_wr.wr_en |-> !$isunknown(c_wr.index)
    ) else $error("C write index unknown");

endmodule

// ==== dv/tpu_checker.sv ====
`timescale 1ns/1ps

module tpu_checker
    import tpu_types_pkg::*;
    import tpu_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     busy,
    input  res_wr_t  c_wr,
    input  res_row_t exp_c [256],
    input  int       exp_writes,
    input  int       exp_cycles,
    output int       errors,
    output int       writes,
    output int       jobs_done
);

    logic busy_q;
    int   job_writes;
    int   job_cycles;
    int   job_errors;
    int   want_writes;
    int   want_cycles;

    task automatic count_error();
        errors++;
        job_errors++;
    endtask

    task automatic check_write();
        mem_idx_t want_idx;
        want_idx = mem_idx_t'(job_writes);
        if (!busy) begin
            $display("C write seen while busy is low");
            count_error();
        end
        if (c_wr.index !== want_idx) begin
            $display("[FAIL] c_wr.index: expected %h, got %h", want_idx, c_wr.index);
            count_error();
        end
        if ($isunknown(c_wr.index) || c_wr.index >= mem_idx_t'(want_writes)) begin
            $display("job %0d: C write index lies outside the result image", jobs_done);
            count_error();
        end else if (c_wr.data !== exp_c[c_wr.index[7:0]]) begin
            $display("[FAIL] c_wr.data at index %h: expected %h, got %h",
                     c_wr.index, exp_c[c_wr.index[7:0]], c_wr.data);
            count_error();
        end
        job_writes++;
    endtask

    // one summary line per job
    task automatic close_job();
        if (job_writes != want_writes) begin
            $display("job %0d: %0d C writes, expected %0d", jobs_done, job_writes, want_writes);
            count_error();
        end
        if (job_cycles != want_cycles) begin
            $display("job %0d: busy for %0d cycles, expected %0d",
                     jobs_done, job_cycles, want_cycles);
            count_error();
        end
        $display("job %0d: %0d writes in %0d busy cycles, %s", jobs_done, job_writes,
                 job_cycles, (job_errors == 0) ? "ok" : "failed");
        writes += job_writes;
        jobs_done++;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     = 1'b0;
            errors     = 0;
            writes     = 0;
            jobs_done  = 0;
            job_writes = 0;
            job_cycles = 0;
            job_errors = 0;
        end else begin
            // job start, take the expected counts
            if (busy && !busy_q) begin
                want_writes = exp_writes;
                want_cycles = exp_cycles;
                job_writes  = 0;
                job_cycles  = 0;
                job_errors  = 0;
            end
            if (busy) begin
                job_cycles++;
            end
            if (c_wr.wr_en) begin
                check_write();
            end
            if (!busy && busy_q) begin
                close_job();
            end
            busy_q = busy;
        end
    end

endmodule

// ==== dv/tpu_tb.sv ====
`timescale 1ns/1ps

module tpu_tb
    import tpu_types_pkg::*;
    import tpu_ctrl_pkg::*;
();

    localparam int VEC_WORDS = 512;
    localparam int MEM_WORDS = 256;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    job_t     job;
    logic     busy;
    mem_idx_t a_idx;
    mem_idx_t b_idx;
    res_wr_t  c_wr;
    op_rd_t   a_port = '0;
    op_rd_t   b_port = '0;

    logic [31:0] vec   [VEC_WORDS];
    op_word_t    a_mem [MEM_WORDS];
    op_word_t    b_mem [MEM_WORDS];
    res_row_t    exp_c [MEM_WORDS];
    int          exp_writes;
    int          exp_cycles;
    int          chk_errors;
    int          chk_writes;
    int          jobs_done;
    int          job_count;
    int          cycle_limit;
    int          cycle_count;
    int          tb_errors;

    tb_clk_gen tb_clk_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tpu_top tpu_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .job      (job),
        .busy     (busy),
        .a_idx    (a_idx),
        .b_idx    (b_idx),
        .a_data   (a_port.data),
        .b_data   (b_port.data),
        .c_wr     (c_wr)
    );

    tpu_checker tpu_checker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .busy       (busy),
        .c_wr       (c_wr),
        .exp_c      (exp_c),
        .exp_writes (exp_writes),
        .exp_cycles (exp_cycles),
        .errors     (chk_errors),
        .writes     (chk_writes),
        .jobs_done  (jobs_done)
    );

    bind tpu_top tpu_assert tpu_assert_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .busy  (busy),
        .c_wr  (c_wr)
    );

    // registered read with data one cycle behind the index
    always @(posedge clk) begin
        a_port <= '{index: a_idx, data: a_mem[a_idx[7:0]]};
        b_port <= '{index: b_idx, data: b_mem[b_idx[7:0]]};
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run timed out after %0d cycles without finishing all jobs", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int tile_count(int dim);
        return (dim + ARRAY_DIM - 1) / ARRAY_DIM;
    endfunction

    // empty operand images and expected rows
    task automatic clear_images();
        for (int i = 0; i < MEM_WORDS; i++) begin
            a_mem[i] = '0;
            b_mem[i] = '0;
            exp_c[i] = '0;
        end
    endtask

    // loads the images and expected rows of one job and moves pos past them
    task automatic load_job(inout int pos, output job_t next_job);
        int r_tiles;
        int c_tiles;
        int k;
        next_job = '{k: dim_t'(vec[pos]), m: dim_t'(vec[pos+1]), n: dim_t'(vec[pos+2]),
                     input_offset: acc_t'(vec[pos+3])};
        k = int'(next_job.k);
        r_tiles = tile_count(int'(next_job.m));
        c_tiles = tile_count(int'(next_job.n));
        pos += 4;
        clear_images();
        for (int i = 0; i < r_tiles * k; i++) begin
            a_mem[i] = vec[pos];
            pos++;
        end
        for (int i = 0; i < c_tiles * k; i++) begin
            b_mem[i] = vec[pos];
            pos++;
        end
        for (int i = 0; i < 4 * r_tiles * c_tiles; i++) begin
            exp_c[i] = {vec[pos], vec[pos+1], vec[pos+2], vec[pos+3]};
            pos += 4;
        end
        exp_writes = 4 * r_tiles * c_tiles;
        exp_cycles = r_tiles * c_tiles * (k + 13);
    endtask

    // starts on a rising edge and returns on the edge where busy is seen low
    task automatic run_job(input job_t next_job, input int num);
        job_t stray;
        stray    = '{k: 8'd3, m: 8'd12, n: 8'd12, input_offset: 32'h1234_5678};
        in_valid <= 1'b1;
        job      <= next_job;
        @(posedge clk);
        in_valid <= 1'b0;
        @(posedge clk);
        if (busy !== 1'b1) begin
            $display("[FAIL] busy one cycle after in_valid of job %0d: expected %h, got %h",
                     num, 1'b1, busy);
            tb_errors++;
        end
        // start pulse during a job must change nothing
        in_valid <= 1'b1;
        job      <= stray;
        @(posedge clk);
        in_valid <= 1'b0;
        job      <= '0;
        while (busy) begin
            @(posedge clk);
        end
    endtask

    initial begin
        int   pos;
        int   r_t;
        int   c_t;
        int   k;
        job_t next_job;
        in_valid    = 1'b0;
        job         = '0;
        tb_errors   = 0;
        cycle_count = 0;
        cycle_limit = 0;
        clear_images();
        $readmemh("dv/tpu_vectors.txt", vec);
        job_count = vec[0];
        if (job_count == 0) begin
            $display("no jobs found in the vector file");
            tb_errors++;
        end
        pos = 1;
        for (int j = 0; j < job_count; j++) begin
            k   = vec[pos];
            r_t = tile_count(vec[pos+1]);
            c_t = tile_count(vec[pos+2]);
            cycle_limit += r_t * c_t * (k + 13) + 20;
            pos += 4 + (r_t + c_t) * k + 16 * r_t * c_t;
        end
        wait (rst_n === 1'b1);
        @(posedge clk);
        pos = 1;
        for (int j = 0; j < job_count; j++) begin
            load_job(pos, next_job);
            run_job(next_job, j);
        end
        repeat (2) @(posedge clk);
        if (jobs_done != job_count) begin
            $display("only %0d of %0d jobs completed", jobs_done, job_count);
            tb_errors++;
        end
        $display("jobs %0d, C writes %0d, errors %0d", jobs_done, chk_writes,
                 chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== dv/tpu_vectors.txt ====
// job count, then per job: K M N offset, A words, B words, then the C rows
// four 32-bit values per row with column 0 first, all hex
4
// single tile, diagonal A, zero offset
4 4 4 0
01000000 00020000 00000300 00000004
01020304 05060708 090a0b0c 0d0e0f10
1 2 3 4  a c e 10  1b 1e 21 24  34 38 3c 40
// negative bytes, offset on A only, sums wrap
2 4 4 40000000
fffe017f 00000000 04fc01ff 04fc01ff
fffffffc 4 7fffffff 80000001  fffffff8 8 7ffffffe 80000002
4 fffffffc 80000001 7fffffff  1fc fffffe04 8000007f 7fffff81
// four tiles with K=1
1 8 8 0
01020304 05060708 01020304 10203040
1 2 3 4  2 4 6 8  3 6 9 c  4 8 c 10
5 a f 14  6 c 12 18  7 e 15 1c  8 10 18 20
10 20 30 40  20 40 60 80  30 60 90 c0  40 80 c0 100
50 a0 f0 140  60 c0 120 180  70 e0 150 1c0  80 100 180 200
// K=20, long accumulation
14 4 4 0
01020304 01020304 01020304 01020304 01020304 01020304 01020304 01020304 01020304 01020304
01020304 01020304 01020304 01020304 01020304 01020304 01020304 01020304 01020304 01020304
01ff007f 01ff017f 01ff027f 01ff037f 01ff047f 01ff057f 01ff067f 01ff077f 01ff087f 01ff097f
01ff0a7f 01ff0b7f 01ff0c7f 01ff0d7f 01ff0e7f 01ff0f7f 01ff107f 01ff117f 01ff127f 01ff137f
14 ffffffec be 9ec  28 ffffffd8 17c 13d8
3c ffffffc4 23a 1dc4  50 ffffffb0 2f8 27b0

// ==== flist.f ====
rtl/tpu_types_pkg.sv
rtl/tpu_ctrl_pkg.sv
rtl/pe.sv
rtl/systolic_array.sv
rtl/operand_skew.sv
rtl/tpu_ctrl.sv
rtl/tpu_top.sv
dv/tb_clk_gen.sv
dv/tpu_assert.sv
dv/tpu_checker.sv
dv/tpu_tb.sv
